// ==== run.sh ====
#!/bin/sh
# Build and run the aluUnit testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
SIM=obj_dir/aluUnitSim

verilator --binary --timing --top-module aluUnitTb -f tb.f --Mdir obj_dir -o aluUnitSim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"$SIM" > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "TESTBENCH FAILED" "$LOG"; then
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi
exit 0

// ==== src/aluExecute.sv ====
// Execute engine, one operation at a time
// ALU ops, one-step shifter and 33x33 multiplier land in a result register
// one cycle after take; divides run through the serial divider
`timescale 1ns/1ns
`default_nettype none

module aluExecute import aluPkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       reqValid,
  input  execReq_t   req,
  input  logic       queueFree, // Result slot reservable
  output logic       reqTake,
  output logic       wrValid,
  output aluResult_t wr
);

  logic [31:0]         in1;
  logic [31:0]         in2;
  logic [2:0]          op;
  logic [4:0]          shamt;
  logic [32:0]         minus;      // in1 - in2, bit 32 is borrow
  logic                lt;
  logic [32:0]         shiftRight;
  logic                in1U;
  logic                in2U;
  logic signed [32:0]  in1E;
  logic signed [32:0]  in2E;
  logic signed [65:0]  times;
  logic [31:0]         fastValue;  // Non-divide result
  logic                isDiv;
  logic                busy;       // Divide in flight
  logic                divStart;
  logic                divDone;
  logic [31:0]         quotient;
  logic [31:0]         remainder;
  logic [TAG_BITS-1:0] divTag;
  logic                divWantsRem;

  assign in1   = req.in1;
  assign in2   = req.in2;
  assign op    = req.ctl.op;
  assign shamt = in2[4:0];

  assign isDiv    = req.ctl.opM & op[2];
  assign reqTake  = reqValid & ~busy & queueFree;
  assign divStart = reqTake & isDiv;

  // One subtract serves SUB, SLT and SLTU
  assign minus = {1'b0, in1} - {1'b0, in2};
  assign lt    = (in1[31] ^ in2[31]) ? in1[31] : minus[32];

  assign shiftRight = 33'($signed({req.ctl.opQual & in1[31], in1}) >>> shamt); // SRL/SRA

  // Per-op sign extension into a single signed multiply
  assign in1U  = (op == 3'b011);        // MULHU
  assign in2U  = op[1];                 // MULHSU, MULHU
  assign in1E  = {in1U ? 1'b0 : in1[31], in1};
  assign in2E  = {in2U ? 1'b0 : in2[31], in2};
  assign times = in1E * in2E;

  always_comb begin
    if (req.ctl.opM) begin
      fastValue = (op == 3'b000) ? times[31:0] : times[63:32]; // MUL vs MULH*
    end else begin
      case (op)
        3'b000:  fastValue = req.ctl.opQual ? minus[31:0] : in1 + in2;
        3'b001:  fastValue = in1 << shamt;     // SLL
        3'b010:  fastValue = {31'b0, lt};      // SLT
        3'b011:  fastValue = {31'b0, minus[32]}; // SLTU
        3'b100:  fastValue = in1 ^ in2;
        3'b101:  fastValue = shiftRight[31:0];
        3'b110:  fastValue = in1 | in2;
        default: fastValue = in1 & in2;
      endcase
    end
  end

  serialDivider div0 (
    .clk       (clk),
    .reset     (reset),
    .divStart  (divStart),
    .dividend  (in1),
    .divisor   (in2),
    .op        (op),
    .divDone   (divDone),
    .quotient  (quotient),
    .remainder (remainder)
  );

  always_ff @(posedge clk) begin
    if (reset) begin
      wrValid <= 1'b0;
      busy    <= 1'b0;
    end else begin
      wrValid <= (reqTake & ~isDiv) | divDone; // Divides write a cycle after done
      if (divStart) begin
        busy <= 1'b1;
      end else if (divDone) begin
        busy <= 1'b0;
      end
    end
  end

  // Result register and divide bookkeeping
  always_ff @(posedge clk) begin
    if (divStart) begin
      divTag      <= req.tag;
      divWantsRem <= op[1]; // REM, REMU
    end
    if (divDone) begin
      wr.tag   <= divTag;
      wr.value <= divWantsRem ? remainder : quotient;
    end else if (reqTake) begin
      wr.tag   <= req.tag;
      wr.value <= fastValue;
    end
  end

endmodule

`default_nettype wire

// ==== src/aluPkg.sv ====
// Shared types for the RV32IM integer execution unit
// Instruction word views, decoded control, request and result records
`default_nettype none

package aluPkg;

  localparam int TAG_BITS = 4; // Instruction tag width

  // R-type view, OP opcode
  typedef struct packed {
    logic [6:0] funct7; // Bit 0 marks RV32M, bit 5 marks SUB/SRA
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } rType_t;

  // I-type view, OP-IMM opcode
  typedef struct packed {
    logic [11:0] imm12; // Bit 10 marks SRAI
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } iType_t;

  // One instruction word, read either way
  typedef union packed {
    rType_t r;
    iType_t i;
  } instWord_t;

  // Decoded operation
  typedef struct packed {
    logic [2:0] op;     // funct3
    logic       opQual; // Subtract or arithmetic shift
    logic       opM;    // RV32M op
  } aluCtl_t;

  // Decode to execute
  typedef struct packed {
    aluCtl_t               ctl;
    logic [31:0]           in1;
    logic [31:0]           in2;
    logic [TAG_BITS-1:0]   tag;
  } execReq_t;

  // Issuer to decode
  typedef struct packed {
    instWord_t             inst;
    logic [31:0]           rs1Val;
    logic [31:0]           rs2Val;
    logic [TAG_BITS-1:0]   tag;
  } issueReq_t;

  // Execute to result queue to consumer
  typedef struct packed {
    logic [TAG_BITS-1:0]   tag;
    logic [31:0]           value;
  } aluResult_t;

endpackage

`default_nettype wire

// ==== src/aluUnit.sv ====
// RV32IM integer execution unit, top level
// Decode buffer, execute engine and result FIFO in a chain,
// credit flow control toward both the issuer and the consumer
`timescale 1ns/1ns
`default_nettype none

module aluUnit import aluPkg::*; #(
  parameter int IN_DEPTH    = 2, // Decode slots and issuer credits
  parameter int QUEUE_DEPTH = 4, // Result FIFO entries
  parameter int OUT_CREDITS = 2  // Consumer's initial grant
) (
  input  logic       clk,
  input  logic       reset,
  input  logic       issueValid,
  input  issueReq_t  issue,
  output logic       inCredit,
  output logic       resValid,
  output aluResult_t res,
  input  logic       outCredit
);

  logic       reqValid;
  execReq_t   req;
  logic       reqTake;
  logic       wrValid;
  aluResult_t wr;
  logic       queueFree;

  instDecode #(
    .IN_DEPTH (IN_DEPTH)
  ) decode0 (
    .clk        (clk),
    .reset      (reset),
    .issueValid (issueValid),
    .issue      (issue),
    .reqTake    (reqTake),
    .inCredit   (inCredit),
    .reqValid   (reqValid),
    .req        (req)
  );

  aluExecute exec0 (
    .clk       (clk),
    .reset     (reset),
    .reqValid  (reqValid),
    .req       (req),
    .queueFree (queueFree),
    .reqTake   (reqTake),
    .wrValid   (wrValid),
    .wr        (wr)
  );

  // Also sees reqTake to reserve a slot for the op in execution
  resultQueue #(
    .QUEUE_DEPTH (QUEUE_DEPTH),
    .OUT_CREDITS (OUT_CREDITS)
  ) queue0 (
    .clk       (clk),
    .reset     (reset),
    .wrValid   (wrValid),
    .wr        (wr),
    .outCredit (outCredit),
    .reqTake   (reqTake),
    .queueFree (queueFree),
    .resValid  (resValid),
    .res       (res)
  );

endmodule

`default_nettype wire

// ==== src/instDecode.sv ====
// Instruction buffer and decoder
// Holds issued instructions in a small FIFO, returns one issue credit
// per entry taken, and decodes the head into an execute request
`timescale 1ns/1ns
`default_nettype none

module instDecode import aluPkg::*; #(
  parameter int IN_DEPTH = 2 // Buffer slots, also issuer start credits
) (
  input  logic      clk,
  input  logic      reset,
  input  logic      issueValid, // Issuer spends a credit
  input  issueReq_t issue,
  input  logic      reqTake,    // Execute accepts head
  output logic      inCredit,   // One slot back to issuer
  output logic      reqValid,
  output execReq_t  req
);

  localparam int PTR_BITS = (IN_DEPTH > 1) ? $clog2(IN_DEPTH) : 1;
  localparam int CNT_BITS = $clog2(IN_DEPTH + 1);

  issueReq_t           slots [IN_DEPTH]; // Payload only
  logic [PTR_BITS-1:0] wrPtr;
  logic [PTR_BITS-1:0] rdPtr;
  logic [CNT_BITS-1:0] count;            // Occupied slots
  issueReq_t           head;
  instWord_t           inst;
  logic                isRType;
  logic                isShiftRight;
  logic                pop;

  assign head     = slots[rdPtr];
  assign inst     = head.inst;
  assign reqValid = (count != '0);
  assign pop      = reqValid & reqTake;
  assign inCredit = pop; // Slot frees as execute takes it

  // OP vs OP-IMM by opcode bit 5 only
  assign isRType      = inst.r.opcode[5];
  assign isShiftRight = (inst.i.funct3 == 3'b101);

  always_comb begin
    req.ctl.op = inst.r.funct3; // Same bits in both views
    req.in1    = head.rs1Val;
    req.tag    = head.tag;
    if (isRType) begin
      req.ctl.opM    = inst.r.funct7[0];
      req.ctl.opQual = inst.r.funct7[5]; // SUB or SRA
      req.in2        = head.rs2Val;
    end else begin
      req.ctl.opM    = 1'b0;
      req.ctl.opQual = isShiftRight & inst.i.imm12[10]; // SRAI only
      req.in2        = {{20{inst.i.imm12[11]}}, inst.i.imm12};
    end
  end

  // Pointers and occupancy
  always_ff @(posedge clk) begin
    if (reset) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (issueValid) begin
        wrPtr <= (wrPtr == PTR_BITS'(IN_DEPTH - 1)) ? '0 : wrPtr + 1'b1;
      end
      if (pop) begin
        rdPtr <= (rdPtr == PTR_BITS'(IN_DEPTH - 1)) ? '0 : rdPtr + 1'b1;
      end
      case ({issueValid, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Issuer never sends without credit, so no full check here
  always_ff @(posedge clk) begin
    if (issueValid) begin
      slots[wrPtr] <= issue;
    end
  end

endmodule

`default_nettype wire

// ==== src/resultQueue.sv ====
// In-order result FIFO with output credits
// Slots are reserved at take time so execute never overruns the FIFO;
// a result goes out only while the consumer has granted credit
`timescale 1ns/1ns
`default_nettype none

module resultQueue import aluPkg::*; #(
  parameter int QUEUE_DEPTH = 4,
  parameter int OUT_CREDITS = 2  // Consumer's initial grant
) (
  input  logic       clk,
  input  logic       reset,
  input  logic       wrValid,
  input  aluResult_t wr,
  input  logic       outCredit, // Consumer returns one credit
  input  logic       reqTake,   // Execute took an op, reserve a slot
  output logic       queueFree,
  output logic       resValid,
  output aluResult_t res
);

  localparam int PTR_BITS  = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
  localparam int CNT_BITS  = $clog2(QUEUE_DEPTH + 1);
  localparam int CRED_BITS = $clog2(OUT_CREDITS + 1);

  aluResult_t           fifo [QUEUE_DEPTH];
  logic [PTR_BITS-1:0]  wrPtr;
  logic [PTR_BITS-1:0]  rdPtr;
  logic [CNT_BITS-1:0]  held;     // Results stored
  logic [CNT_BITS-1:0]  reserved; // Stored plus in execution
  logic [CRED_BITS-1:0] credits;
  logic                 send;

  assign send      = (held != '0) && (credits != '0);
  assign resValid  = send;
  assign res       = fifo[rdPtr];
  assign queueFree = (reserved < CNT_BITS'(QUEUE_DEPTH));

  always_ff @(posedge clk) begin
    if (reset) begin
      wrPtr    <= '0;
      rdPtr    <= '0;
      held     <= '0;
      reserved <= '0;
      credits  <= CRED_BITS'(OUT_CREDITS);
    end else begin
      if (wrValid) begin
        wrPtr <= (wrPtr == PTR_BITS'(QUEUE_DEPTH - 1)) ? '0 : wrPtr + 1'b1;
      end
      if (send) begin
        rdPtr <= (rdPtr == PTR_BITS'(QUEUE_DEPTH - 1)) ? '0 : rdPtr + 1'b1;
      end
      case ({wrValid, send})
        2'b10:   held <= held + 1'b1;
        2'b01:   held <= held - 1'b1;
        default: held <= held;
      endcase
      case ({reqTake, send})
        2'b10:   reserved <= reserved + 1'b1;
        2'b01:   reserved <= reserved - 1'b1;
        default: reserved <= reserved;
      endcase
      case ({outCredit, send}) // Each send spends one credit
        2'b10:   credits <= credits + 1'b1;
        2'b01:   credits <= credits - 1'b1;
        default: credits <= credits;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (wrValid) begin
      fifo[wrPtr] <= wr;
    end
  end

endmodule

`default_nettype wire

// ==== src/serialDivider.sv ====
// Restoring divider for DIV, DIVU, REM and REMU
// One quotient bit per cycle over 32 steps, operands as magnitudes,
// sign applied to the requested result on the last step
`timescale 1ns/1ns
`default_nettype none

module serialDivider (
  input  logic        clk,
  input  logic        reset,
  input  logic        divStart,
  input  logic [31:0] dividend,
  input  logic [31:0] divisor,
  input  logic [2:0]  op,        // funct3 of the divide
  output logic        divDone,   // One cycle after the last step
  output logic [31:0] quotient,
  output logic [31:0] remainder
);

  logic [31:0] rem;      // Partial remainder
  logic [62:0] den;      // Divisor, walks right one bit per step
  logic [31:0] quo;
  logic [31:0] mask;     // Current quotient bit, zero when idle
  logic        quoNeg;
  logic        remNeg;
  logic        isSigned;
  logic        start;
  logic [31:0] absA;
  logic [31:0] absB;
  logic        fits;
  logic [31:0] remNext;
  logic [31:0] quoNext;

  assign isSigned = ~op[0];           // DIV, REM
  assign start    = divStart & op[2];

  assign absA = (isSigned & dividend[31]) ? -dividend : dividend;
  assign absB = (isSigned & divisor[31]) ? -divisor : divisor;

  // Restoring step
  assign fits    = (den <= {31'b0, rem});
  assign remNext = fits ? rem - den[31:0] : rem;
  assign quoNext = fits ? (quo | mask) : quo;

  always_ff @(posedge clk) begin
    if (reset) begin
      mask    <= '0;
      divDone <= 1'b0;
    end else begin
      divDone <= mask[0]; // Last step this cycle
      if (start) begin
        mask <= 32'h8000_0000;
      end else begin
        mask <= mask >> 1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      rem <= absA;
      den <= {absB, 31'b0};
      quo <= '0;
      // Zero divisor keeps quotient all ones, overflow case needs no fixup
      quoNeg <= isSigned & ~op[1] & (dividend[31] ^ divisor[31]) & (|divisor);
      remNeg <= isSigned & op[1] & dividend[31]; // Remainder follows dividend
    end else if (|mask) begin
      rem <= remNext;
      den <= den >> 1;
      quo <= quoNext;
      if (mask[0]) begin
        quotient  <= quoNeg ? -quoNext : quoNext;
        remainder <= remNeg ? -remNext : remNext;
      end
    end
  end

endmodule

`default_nettype wire

// ==== tb.f ====
src/aluPkg.sv
src/serialDivider.sv
src/instDecode.sv
src/aluExecute.sv
src/resultQueue.sv
src/aluUnit.sv
tb/aluUnitTb.sv

// ==== tb/aluGolden.txt ====
// Columns after vec: instruction word, rs1 value, rs2 value, expected result, all hex
// A sec line names the group of vectors below it
sec rtype
vec 003100B3 7FFFFFFF 00000001 80000000
vec 403100B3 00000000 00000001 FFFFFFFF
vec 003120B3 80000000 7FFFFFFF 00000001
vec 003120B3 00000005 FFFFFFFB 00000000
vec 003130B3 FFFFFFFF 00000000 00000000
vec 003130B3 00000000 FFFFFFFF 00000001
vec 003140B3 F0F0F0F0 0FF00FF0 FF00FF00
vec 003160B3 F0F0F0F0 0FF00FF0 FFF0FFF0
vec 003170B3 F0F0F0F0 0FF00FF0 00F000F0
vec 403150B3 80000010 00000024 F8000001
sec itype
vec FFF10093 00000010 DEADBEEF 0000000F
vec FFB12093 FFFFFFFA DEADBEEF 00000001
vec FFF13093 00000007 DEADBEEF 00000001
vec 7FF14093 0000FFFF DEADBEEF 0000F800
vec 80016093 00000001 DEADBEEF FFFFF801
vec F0F17093 12345678 DEADBEEF 12345608
vec 00411093 8765432F DEADBEEF 765432F0
vec 00815093 F0000000 DEADBEEF 00F00000
vec 40815093 F0000000 DEADBEEF FFF00000
sec mul
vec 023100B3 FFFFFFFE 00000003 FFFFFFFA
vec 023110B3 FFFFFFFE 00000003 FFFFFFFF
vec 023110B3 80000000 80000000 40000000
vec 023120B3 FFFFFFFE FFFFFFFF FFFFFFFE
vec 023130B3 FFFFFFFF FFFFFFFF FFFFFFFE
vec 023130B3 80000000 00000004 00000002
sec div
vec 023140B3 FFFFFFF9 00000002 FFFFFFFD
vec 023160B3 FFFFFFF9 00000002 FFFFFFFF
vec 023150B3 FFFFFFF9 00000002 7FFFFFFC
vec 023170B3 FFFFFFF9 00000002 00000001
vec 023140B3 00000064 FFFFFFF9 FFFFFFF2
vec 023160B3 00000064 FFFFFFF9 00000002
vec 023140B3 00000005 00000000 FFFFFFFF
vec 023160B3 FFFFFFFB 00000000 FFFFFFFB
vec 023150B3 00000005 00000000 FFFFFFFF
vec 023140B3 80000000 FFFFFFFF 80000000
vec 023160B3 80000000 FFFFFFFF 00000000

// ==== tb/aluUnitTb.sv ====
// Testbench for the RV32IM execution unit
// Replays golden vectors through the issue credit interface, returns
// consumer credits at random and checks values, order and credit counts
`timescale 1ns/1ns
`default_nettype none

module aluUnitTb import aluPkg::*; ();

  localparam int IN_DEPTH    = 2;
  localparam int QUEUE_DEPTH = 4;
  localparam int OUT_CREDITS = 2;
  localparam int DRIVE       = 5;    // ns after rising edge
  localparam int CREDIT_WAIT = 200;  // Cycles
  localparam int DRAIN_WAIT  = 4000;
  localparam logic [31:0] SEED = 32'hba73_413a;
  localparam logic [63:0] KEY_NOTE = 64'("//");
  localparam logic [63:0] KEY_SEC  = 64'("sec");
  localparam logic [63:0] KEY_VEC  = 64'("vec");

  logic       clk;
  logic       reset;
  logic       issueValid;
  issueReq_t  issue;
  logic       inCredit;
  logic       resValid;
  aluResult_t res;
  logic       outCredit;

  logic [31:0] vInst [$]; // Golden vectors
  logic [31:0] vRs1  [$];
  logic [31:0] vRs2  [$];
  logic [31:0] vExp  [$];
  logic [63:0] vSec  [$];
  aluResult_t  expQ  [$]; // Scoreboard in issue order
  int          idxQ  [$];

  int          issuedCount   = 0;
  int          creditsBack   = 0; // inCredit pulses seen
  int          receivedCount = 0;
  int          creditsSeen   = 0; // outCredit pulses seen
  logic [31:0] drvRand;
  logic [31:0] consRand;

  aluUnit #(
    .IN_DEPTH    (IN_DEPTH),
    .QUEUE_DEPTH (QUEUE_DEPTH),
    .OUT_CREDITS (OUT_CREDITS)
  ) dut0 (
    .clk        (clk),
    .reset      (reset),
    .issueValid (issueValid),
    .issue      (issue),
    .inCredit   (inCredit),
    .resValid   (resValid),
    .res        (res),
    .outCredit  (outCredit)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic abortRun(input string why);
    $display("%0s", why);
    $display("TESTBENCH FAILED");
    $fatal(1, "Simulation stopped on first error");
  endtask

  task automatic stepCycle();
    @(posedge clk);
    #DRIVE;
  endtask

  function automatic logic [31:0] lcgStep(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic checkResult(input string name, input aluResult_t expected,
                             input aluResult_t actual);
    if (expected != actual) begin
      abortRun($sformatf("Mismatch %0s: expected tag %0d value %08h, actual tag %0d value %08h",
                         name, expected.tag, expected.value, actual.tag, actual.value));
    end
  endtask

  task automatic checkCredits(input string name, input int expected, input int actual);
    if (expected != actual) begin
      abortRun($sformatf("Mismatch %0s: expected %0d, actual %0d", name, expected, actual));
    end
  endtask

  // One keyword per line and comments skipped to end of line
  task automatic loadVectors();
    int          fd;
    int          code;
    int          c;
    logic [63:0] tok;
    logic [63:0] section;
    logic [31:0] wInst;
    logic [31:0] wRs1;
    logic [31:0] wRs2;
    logic [31:0] wExp;
    fd = $fopen("tb/aluGolden.txt", "r");
    if (fd == 0) begin
      abortRun("Could not open tb/aluGolden.txt");
    end
    section = 64'("none");
    code = $fscanf(fd, "%s", tok);
    while (code == 1) begin
      if (tok == KEY_NOTE) begin
        c = $fgetc(fd);
        while (c != 10 && c != -1) begin
          c = $fgetc(fd);
        end
      end else if (tok == KEY_SEC) begin
        code = $fscanf(fd, "%s", section);
      end else if (tok == KEY_VEC) begin
        code = $fscanf(fd, "%h %h %h %h", wInst, wRs1, wRs2, wExp);
        if (code != 4) begin
          abortRun("Golden file holds a vector line with missing fields");
        end
        vInst.push_back(wInst);
        vRs1.push_back(wRs1);
        vRs2.push_back(wRs2);
        vExp.push_back(wExp);
        vSec.push_back(section);
      end else begin
        abortRun("Golden file holds a line with an unknown keyword");
      end
      code = $fscanf(fd, "%s", tok);
    end
    $fclose(fd);
    if (vInst.size() == 0) begin
      abortRun("Golden file holds no vectors");
    end
  endtask

  // Waits for an issue credit and drives one vector for a cycle
  task automatic issueVector(input int i);
    aluResult_t want;
    int         waited;
    waited = 0;
    while (IN_DEPTH - issuedCount + creditsBack == 0) begin
      stepCycle();
      waited++;
      if (waited > CREDIT_WAIT) begin
        abortRun("Timed out waiting for an issue credit from the DUT");
      end
    end
    issue.inst   = vInst[i];
    issue.rs1Val = vRs1[i];
    issue.rs2Val = vRs2[i];
    issue.tag    = TAG_BITS'(issuedCount); // Counter modulo 16
    issueValid   = 1'b1;
    want.tag     = issue.tag;
    want.value   = vExp[i];
    expQ.push_back(want);
    idxQ.push_back(i);
    issuedCount++;
  endtask

  task automatic takeResult();
    aluResult_t want;
    int         idx;
    if (receivedCount + 1 > OUT_CREDITS + creditsSeen) begin
      abortRun("DUT sent a result without holding an output credit");
    end
    if (expQ.size() == 0) begin
      abortRun("DUT sent a result with no instruction outstanding");
    end
    want = expQ.pop_front();
    idx  = idxQ.pop_front();
    checkResult($sformatf("%0s vector %0d", vSec[idx], idx), want, res);
    receivedCount++;
  endtask

  // Mid-cycle sampling while outputs are settled
  always @(negedge clk) begin
    if (!reset) begin
      if (inCredit) begin
        creditsBack++;
      end
      if (resValid) begin
        takeResult(); // Before counting this cycle's credit
      end
      if (outCredit) begin
        creditsSeen++;
      end
    end
  end

  // Consumer returns credits for held results at random
  initial begin
    outCredit = 1'b0;
    consRand  = SEED ^ 32'h1f3d_5b79;
    forever begin
      stepCycle();
      consRand  = lcgStep(consRand);
      outCredit = (receivedCount > creditsSeen) && (consRand[20:18] < 3'd3);
    end
  end

  initial begin
    int waited;
    reset      = 1'b1;
    issueValid = 1'b0;
    issue      = '0;
    drvRand    = SEED;
    loadVectors();
    repeat (16) stepCycle();
    reset = 1'b0;
    for (int i = 0; i < vInst.size(); i++) begin
      drvRand = lcgStep(drvRand);
      repeat (drvRand[17:16]) stepCycle(); // Random issue gap
      issueVector(i);
      stepCycle();
      issueValid = 1'b0;
    end
    waited = 0;
    while (receivedCount < vInst.size() || creditsSeen < receivedCount) begin
      stepCycle();
      waited++;
      if (waited > DRAIN_WAIT) begin
        abortRun("Timed out waiting for all results and credits to drain");
      end
    end
    checkCredits("inCredit pulses", issuedCount, creditsBack);
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire
